//--- Bender.yml
package:
  name: csi_tx_frontend

export_include_dirs:
  - include

sources:
  - files:
      - logic/csi_pkg.sv
      - logic/raw10_packer.sv
      - logic/payload_fifo.sv
      - logic/csi_crc16.sv
      - logic/csi_packet_formatter.sv
      - logic/csi_tx_frontend.sv
  - target: simulation
    files:
      - tb/csi_tx_frontend_chk.sv
      - tb/csi_stream_monitor.sv
      - tb/tb_csi_tx_frontend.sv

//--- csi_tx_frontend.f
+incdir+include
logic/csi_pkg.sv
logic/raw10_packer.sv
logic/payload_fifo.sv
logic/csi_crc16.sv
logic/csi_packet_formatter.sv
logic/csi_tx_frontend.sv
tb/csi_tx_frontend_chk.sv
tb/csi_stream_monitor.sv
tb/tb_csi_tx_frontend.sv

//--- include/csi_config.svh
// ###########################################################################
// build-time sizing for the CSI-2 transmit front end
// line geometry, payload word count, FIFO depth and CRC seed
// ###########################################################################
`ifndef CSI_CONFIG_SVH
`define CSI_CONFIG_SVH

`default_nettype none

// pixels per line, keep a multiple of 4 for whole RAW10 groups
`define CSI_LINE_PIXELS 16

// payload bytes per line, 5 bytes per 4 pixels
`define CSI_LINE_WC ((`CSI_LINE_PIXELS * 10) / 8)

// power of two, must hold one full line
`define CSI_FIFO_DEPTH 32

// CSI-2 CRC starts from all ones
`define CSI_CRC_SEED 16'hFFFF

`default_nettype wire

`endif

//--- logic/csi_crc16.sv
// ###########################################################################
// CSI-2 payload CRC-16, x^16+x^12+x^5+1
// reflected, LSB first, one byte per enabled cycle
// ###########################################################################
`timescale 1ns/100ps
`include "csi_config.svh"
`default_nettype none

module csi_crc16 (
    input  wire         byte_clk,
    input  wire         reset_n_byte,
    input  wire         clear_i,
    input  wire         en_i,
    input  wire  [7:0]  data_i,
    output logic [15:0] crc_o
);
    // fold one byte, bit 0 first
    function automatic logic [15:0] crc_byte(input logic [15:0] crc, input logic [7:0] d);
        logic [15:0] c;
        logic        fb;
        c = crc;
        for (int i = 0; i < 8; i++) begin
            fb = c[0] ^ d[i];
            c  = c >> 1;
            // 0x8408 is 0x1021 bit-reversed
            if (fb) begin
                c = c ^ 16'h8408;
            end
        end
        return c;
    endfunction

    always_ff @(posedge byte_clk or negedge reset_n_byte) begin
        if (!reset_n_byte) begin
            crc_o <= `CSI_CRC_SEED;
        end else if (clear_i) begin
            crc_o <= `CSI_CRC_SEED;
        end else if (en_i) begin
            crc_o <= crc_byte(crc_o, data_i);
        end
    end

endmodule

`default_nettype wire

//--- logic/csi_packet_formatter.sv
// ###########################################################################
// CSI-2 packet formatter
// pending FS / line / FE requests, header with ECC, payload pops, CRC footer
// ###########################################################################
`timescale 1ns/100ps
`include "csi_config.svh"
`default_nettype none

module csi_packet_formatter (
    input  wire                       byte_clk,
    input  wire                       reset_n_byte,
    input  wire  [1:0]                vc_i,
    input  csi_pkg::frame_event_t     events_i,
    input  wire  [7:0]                fifo_data_i,
    input  wire                       fifo_empty_i,
    output logic                      fifo_rd_o,
    input  wire  [15:0]               crc_i,
    output logic                      crc_clear_o,
    output logic                      crc_en_o,
    output csi_pkg::byte_beat_t       tx_beat_o,
    output logic                      hs_req_o
);
    import csi_pkg::*;

    fmt_state_e  state_q;
    logic [15:0] cnt_q;
    logic        pend_fs_q;
    logic        pend_ln_q;
    logic        pend_fe_q;
    pkt_hdr_t    hdr_q;
    pkt_hdr_t    hdr_d;
    logic        serve_fs;
    logic        serve_ln;
    logic        serve_fe;
    logic        serve_any;
    logic        is_long;
    logic [7:0]  hdr_byte;
    logic [7:0]  tx_data_d;
    logic        tx_en_d;
    logic        hs_d;
    logic [7:0]  tx_data_q;
    logic        tx_en_q;
    logic        hs_q;

    // CSI-2 header ECC, D[7:0] is DI and D[23:8] is WC
    function automatic logic [5:0] hdr_ecc(input pkt_hdr_t hdr);
        logic [23:0] d;
        logic [5:0]  p;
        d    = {hdr.wc, hdr.vc, hdr.dt};
        // one mask per parity bit, from the Hamming table
        p[0] = ^(d & 24'hF12CB7);
        p[1] = ^(d & 24'hF2555B);
        p[2] = ^(d & 24'h749A6D);
        p[3] = ^(d & 24'hB8E38E);
        p[4] = ^(d & 24'hDF03F0);
        p[5] = ^(d & 24'hEFFC00);
        return p;
    endfunction

    // fixed service order, FS then line then FE
    assign serve_any = (state_q == FMT_IDLE) & (pend_fs_q | pend_ln_q | pend_fe_q);
    assign serve_fs  = serve_any & pend_fs_q;
    assign serve_ln  = serve_any & ~pend_fs_q & pend_ln_q;
    assign serve_fe  = serve_any & ~pend_fs_q & ~pend_ln_q;

    always_comb begin
        hdr_d.vc = vc_i;
        hdr_d.dt = DT_FRAME_END;
        hdr_d.wc = 16'd0;
        if (serve_fs) begin
            hdr_d.dt = DT_FRAME_START;
        end else if (serve_ln) begin
            hdr_d.dt = DT_RAW10;
            hdr_d.wc = 16'(`CSI_LINE_WC);
        end
    end

    assign is_long = (hdr_q.dt == DT_RAW10);

    // DI, WC low, WC high, ECC
    always_comb begin
        case (cnt_q[1:0])
            2'd0:    hdr_byte = {hdr_q.vc, hdr_q.dt};
            2'd1:    hdr_byte = hdr_q.wc[7:0];
            2'd2:    hdr_byte = hdr_q.wc[15:8];
            default: hdr_byte = {2'b00, hdr_ecc(hdr_q)};
        endcase
    end

    // per-state byte select and side controls
    always_comb begin
        fifo_rd_o   = 1'b0;
        crc_en_o    = 1'b0;
        crc_clear_o = 1'b0;
        tx_en_d     = 1'b0;
        hs_d        = 1'b0;
        tx_data_d   = 8'h00;
        case (state_q)
            FMT_IDLE: begin
                // fresh CRC for each long packet
                crc_clear_o = serve_ln;
            end
            FMT_HDR: begin
                tx_en_d   = 1'b1;
                hs_d      = 1'b1;
                tx_data_d = hdr_byte;
            end
            FMT_PAYLOAD: begin
                // empty FIFO only gaps the beat, HS stays up
                hs_d = 1'b1;
                if (!fifo_empty_i) begin
                    fifo_rd_o = 1'b1;
                    crc_en_o  = 1'b1;
                    tx_en_d   = 1'b1;
                    tx_data_d = fifo_data_i;
                end
            end
            default: begin
                tx_en_d   = 1'b1;
                hs_d      = 1'b1;
                tx_data_d = cnt_q[0] ? crc_i[15:8] : crc_i[7:0];
            end
        endcase
    end

    always_ff @(posedge byte_clk or negedge reset_n_byte) begin
        if (!reset_n_byte) begin
            state_q   <= FMT_IDLE;
            cnt_q     <= 16'd0;
            pend_fs_q <= 1'b0;
            pend_ln_q <= 1'b0;
            pend_fe_q <= 1'b0;
            tx_en_q   <= 1'b0;
            hs_q      <= 1'b0;
        end else begin
            // a new event re-arms even while its flag is served
            pend_fs_q <= (pend_fs_q & ~serve_fs) | events_i.fv_start;
            pend_ln_q <= (pend_ln_q & ~serve_ln) | events_i.lv_start;
            pend_fe_q <= (pend_fe_q & ~serve_fe) | events_i.fv_end;
            tx_en_q   <= tx_en_d;
            hs_q      <= hs_d;
            case (state_q)
                FMT_IDLE: begin
                    cnt_q <= 16'd0;
                    if (serve_any) begin
                        state_q <= FMT_HDR;
                    end
                end
                FMT_HDR: begin
                    if (cnt_q[1:0] == 2'd3) begin
                        cnt_q   <= 16'd0;
                        state_q <= is_long ? FMT_PAYLOAD : FMT_IDLE;
                    end else begin
                        cnt_q <= cnt_q + 16'd1;
                    end
                end
                FMT_PAYLOAD: begin
                    if (!fifo_empty_i) begin
                        if (cnt_q == hdr_q.wc - 16'd1) begin
                            cnt_q   <= 16'd0;
                            state_q <= FMT_CRC;
                        end else begin
                            cnt_q <= cnt_q + 16'd1;
                        end
                    end
                end
                default: begin
                    // low byte then high byte
                    if (cnt_q[0]) begin
                        cnt_q   <= 16'd0;
                        state_q <= FMT_IDLE;
                    end else begin
                        cnt_q <= cnt_q + 16'd1;
                    end
                end
            endcase
        end
    end

    // header and output byte
    always_ff @(posedge byte_clk) begin
        if (serve_any) begin
            hdr_q <= hdr_d;
        end
        tx_data_q <= tx_data_d;
    end

    assign tx_beat_o = '{data: tx_data_q, en: tx_en_q};
    assign hs_req_o  = hs_q;

endmodule

`default_nettype wire

//--- logic/csi_pkg.sv
// ###########################################################################
// shared types for the CSI-2 transmit front end
// data type codes, formatter states, frame strobes, byte beats, headers
// ###########################################################################
`default_nettype none

package csi_pkg;

    // CSI-2 data identifier type field, 6 bits
    typedef enum logic [5:0] {
        DT_FRAME_START = 6'h00,
        DT_FRAME_END   = 6'h01,
        DT_RAW10       = 6'h2B
    } csi_data_type_e;

    // packet formatter FSM
    typedef enum logic [1:0] {
        FMT_IDLE,
        FMT_HDR,
        FMT_PAYLOAD,
        FMT_CRC
    } fmt_state_e;

    // one-cycle edge strobes from the pixel side
    typedef struct packed {
        logic fv_start;
        logic fv_end;
        logic lv_start;
        logic lv_end;
    } frame_event_t;

    // byte with its qualifier
    typedef struct packed {
        logic [7:0] data;
        logic       en;
    } byte_beat_t;

    // packet header fields, DI is {vc, dt}
    typedef struct packed {
        logic [1:0]     vc;
        csi_data_type_e dt;
        logic [15:0]    wc;
    } pkt_hdr_t;

endpackage

`default_nettype wire

//--- logic/csi_tx_frontend.sv
// ###########################################################################
// CSI-2 transmit front end top level
// packer, payload FIFO, packet formatter and CRC on byte_clk
// ###########################################################################
`timescale 1ns/100ps
`default_nettype none

module csi_tx_frontend (
    input  wire                   byte_clk,
    input  wire                   reset_n_byte,
    input  wire  [9:0]            pixel_i,
    input  wire                   pixel_valid_i,
    input  wire                   fv_i,
    input  wire                   lv_i,
    input  wire  [1:0]            vc_i,
    output csi_pkg::byte_beat_t   tx_beat_o,
    output logic                  hs_req_o
);
    import csi_pkg::*;

    frame_event_t events;
    byte_beat_t   wr_beat;
    logic         fifo_rd;
    logic [7:0]   fifo_data;
    logic         fifo_empty;
    // only the bound checker looks at full
    logic         fifo_full;
    logic         crc_clear;
    logic         crc_en;
    logic [15:0]  crc;

    raw10_packer raw10_packer_inst (
        .byte_clk      (byte_clk),
        .reset_n_byte  (reset_n_byte),
        .pixel_i       (pixel_i),
        .pixel_valid_i (pixel_valid_i),
        .fv_i          (fv_i),
        .lv_i          (lv_i),
        .events_o      (events),
        .wr_beat_o     (wr_beat)
    );

    payload_fifo payload_fifo_inst (
        .byte_clk     (byte_clk),
        .reset_n_byte (reset_n_byte),
        .wr_beat_i    (wr_beat),
        .rd_en_i      (fifo_rd),
        .rd_data_o    (fifo_data),
        .empty_o      (fifo_empty),
        .full_o       (fifo_full)
    );

    // CRC sees the FIFO head, enabled on each pop
    csi_crc16 csi_crc16_inst (
        .byte_clk     (byte_clk),
        .reset_n_byte (reset_n_byte),
        .clear_i      (crc_clear),
        .en_i         (crc_en),
        .data_i       (fifo_data),
        .crc_o        (crc)
    );

    csi_packet_formatter csi_packet_formatter_inst (
        .byte_clk     (byte_clk),
        .reset_n_byte (reset_n_byte),
        .vc_i         (vc_i),
        .events_i     (events),
        .fifo_data_i  (fifo_data),
        .fifo_empty_i (fifo_empty),
        .fifo_rd_o    (fifo_rd),
        .crc_i        (crc),
        .crc_clear_o  (crc_clear),
        .crc_en_o     (crc_en),
        .tx_beat_o    (tx_beat_o),
        .hs_req_o     (hs_req_o)
    );

endmodule

`default_nettype wire

//--- logic/payload_fifo.sv
// ###########################################################################
// synchronous byte FIFO for one line of payload
// first-word-fall-through head, fill count, empty and full flags
// ###########################################################################
`timescale 1ns/100ps
`include "csi_config.svh"
`default_nettype none

module payload_fifo (
    input  wire                   byte_clk,
    input  wire                   reset_n_byte,
    input  csi_pkg::byte_beat_t   wr_beat_i,
    input  wire                   rd_en_i,
    output logic [7:0]            rd_data_o,
    output logic                  empty_o,
    output logic                  full_o
);
    localparam int DEPTH = `CSI_FIFO_DEPTH;
    localparam int AW    = $clog2(DEPTH);

    logic [7:0]  mem [DEPTH];
    logic [AW-1:0] wr_ptr_q;
    logic [AW-1:0] rd_ptr_q;
    logic [AW:0]   count_q;
    logic          do_wr;
    logic          do_rd;

    // drop writes when full, ignore reads when empty
    assign do_wr = wr_beat_i.en & ~full_o;
    assign do_rd = rd_en_i & ~empty_o;

    always_ff @(posedge byte_clk or negedge reset_n_byte) begin
        if (!reset_n_byte) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_rd) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            // simultaneous push and pop leaves the count alone
            if (do_wr && !do_rd) begin
                count_q <= count_q + 1'b1;
            end else if (do_rd && !do_wr) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge byte_clk) begin
        if (do_wr) begin
            mem[wr_ptr_q] <= wr_beat_i.data;
        end
    end

    // head byte visible without a read
    assign rd_data_o = mem[rd_ptr_q];
    assign empty_o   = (count_q == '0);
    assign full_o    = (count_q == (AW+1)'(DEPTH));

endmodule

`default_nettype wire

//--- logic/raw10_packer.sv
// ###########################################################################
// frame and line edge detection
// RAW10 packing, 4 pixels into 4 MSB bytes plus 1 shared LSB byte
// ###########################################################################
`timescale 1ns/100ps
`default_nettype none

module raw10_packer (
    input  wire                       byte_clk,
    input  wire                       reset_n_byte,
    input  wire  [9:0]                pixel_i,
    input  wire                       pixel_valid_i,
    input  wire                       fv_i,
    input  wire                       lv_i,
    output csi_pkg::frame_event_t     events_o,
    output csi_pkg::byte_beat_t       wr_beat_o
);
    import csi_pkg::*;

    logic       fv_q;
    logic       lv_q;
    logic [1:0] slot_q;
    logic [5:0] lsb_buf_q;
    logic [7:0] lsb_hold_q;
    logic       lsb_pend_q;
    logic       wr_en_q;
    logic [7:0] wr_data_q;
    logic       pix_ok;

    // pixels only count inside a line
    assign pix_ok = pixel_valid_i & lv_i;

    // edge strobes land one cycle after the level change
    always_ff @(posedge byte_clk or negedge reset_n_byte) begin
        if (!reset_n_byte) begin
            fv_q     <= 1'b0;
            lv_q     <= 1'b0;
            events_o <= '0;
        end else begin
            fv_q              <= fv_i;
            lv_q              <= lv_i;
            events_o.fv_start <= fv_i & ~fv_q;
            events_o.fv_end   <= ~fv_i & fv_q;
            events_o.lv_start <= lv_i & ~lv_q;
            events_o.lv_end   <= ~lv_i & lv_q;
        end
    end

    // slot counter and LSB byte bookkeeping
    always_ff @(posedge byte_clk or negedge reset_n_byte) begin
        if (!reset_n_byte) begin
            slot_q     <= 2'd0;
            lsb_pend_q <= 1'b0;
            wr_en_q    <= 1'b0;
        end else begin
            // realign groups at every line start
            if (!lv_i) begin
                slot_q <= 2'd0;
            end else if (pix_ok) begin
                slot_q <= slot_q + 2'd1;
            end
            if (pix_ok && (slot_q == 2'd3)) begin
                lsb_pend_q <= 1'b1;
            end else if (!pix_ok) begin
                // free cycle goes to the LSB byte
                lsb_pend_q <= 1'b0;
            end
            wr_en_q <= pix_ok | lsb_pend_q;
        end
    end

    // byte data, pixel MSBs win over a waiting LSB byte
    always_ff @(posedge byte_clk) begin
        if (pix_ok) begin
            wr_data_q <= pixel_i[9:2];
            case (slot_q)
                2'd0: lsb_buf_q[1:0] <= pixel_i[1:0];
                2'd1: lsb_buf_q[3:2] <= pixel_i[1:0];
                2'd2: lsb_buf_q[5:4] <= pixel_i[1:0];
                // group complete, park it so the next group can start
                default: lsb_hold_q <= {pixel_i[1:0], lsb_buf_q};
            endcase
        end else if (lsb_pend_q) begin
            wr_data_q <= lsb_hold_q;
        end
    end

    assign wr_beat_o = '{data: wr_data_q, en: wr_en_q};

endmodule

`default_nettype wire

//--- tb/csi_stream_monitor.sv
// ###########################################################################
// CSI-2 output stream monitor
// packet framing, reference ECC, RAW10 packing and CRC-16, error counts
// ###########################################################################
`timescale 1ns/100ps
`include "csi_config.svh"
`default_nettype none

module csi_stream_monitor #(
    parameter int LINES = 4
) (
    input  wire                   byte_clk,
    input  wire                   reset_n_byte,
    input  csi_pkg::byte_beat_t   tx_beat_i,
    input  wire                   hs_req_i
);
    import csi_pkg::*;

    localparam int WC  = `CSI_LINE_WC;
    localparam int PIX = `CSI_LINE_PIXELS;

    // Hamming column per header bit, D23 down to D0
    localparam logic [143:0] ECC_COLS = {
        6'h3B, 6'h37, 6'h2F, 6'h1F, 6'h38, 6'h34, 6'h32, 6'h31,
        6'h2C, 6'h2A, 6'h29, 6'h26, 6'h25, 6'h23, 6'h1C, 6'h1A,
        6'h19, 6'h16, 6'h15, 6'h13, 6'h0E, 6'h0D, 6'h0B, 6'h07
    };

    // filled by the stimulus ahead of each frame and line
    logic [9:0] pix_q [$];
    logic [1:0] vc_q [$];

    int         check_count = 0;
    int         err_count   = 0;
    int         pkt_count   = 0;
    // 0 is FS, 1..LINES the lines, LINES+1 is FE
    int         seq_pos     = 0;
    logic [1:0] cur_vc      = 2'd0;
    logic       hs_prev     = 1'b0;
    logic       last_en     = 1'b0;
    logic [7:0] pkt_bytes [$];
    logic [7:0] exp_pay [WC];

    // XOR of the columns of all set header bits
    function automatic logic [5:0] ref_ecc(input logic [23:0] d);
        logic [5:0] p;
        int         i;
        p = 6'h00;
        for (i = 0; i < 24; i++) begin
            if (d[i]) begin
                p = p ^ ECC_COLS[6*i +: 6];
            end
        end
        return p;
    endfunction

    // serial x^16+x^12+x^5+1, data bit 0 enters first
    function automatic logic [15:0] ref_crc_byte(input logic [15:0] c, input logic [7:0] d);
        logic [15:0] r;
        logic        fb;
        int          i;
        r = c;
        for (i = 0; i < 8; i++) begin
            fb    = r[0] ^ d[i];
            r     = {fb, r[15:1]};
            r[10] = r[10] ^ fb;
            r[3]  = r[3] ^ fb;
        end
        return r;
    endfunction

    // byte k of a 4-pixel group, pixel 0 in grp[9:0]
    function automatic logic [7:0] raw10_byte(input logic [39:0] grp, input int k);
        if (k < 4) begin
            return grp[10*k+2 +: 8];
        end
        return {grp[31:30], grp[21:20], grp[11:10], grp[1:0]};
    endfunction

    task automatic report_error(input string msg);
        err_count++;
        $display("ERROR time=%0t: %s", $time, msg);
    endtask

    task automatic compare_byte(input string sig, input logic [7:0] exp_v,
                                input logic [7:0] act_v);
        check_count++;
        if (act_v !== exp_v) begin
            err_count++;
            $display("CHECK FAILED time=%0t signal=%s expected=0x%02h actual=0x%02h",
                     $time, sig, exp_v, act_v);
        end
    endtask

    // expected payload of the next line from the queued pixels
    task automatic build_payload();
        logic [39:0] grp;
        int          g;
        int          k;
        if (pix_q.size() < PIX) begin
            report_error("long packet seen but the line's pixels were never queued");
        end
        for (g = 0; g < PIX / 4; g++) begin
            for (k = 0; k < 4; k++) begin
                grp[10*k +: 10] = (pix_q.size() > 0) ? pix_q.pop_front() : 10'd0;
            end
            for (k = 0; k < 5; k++) begin
                exp_pay[5*g+k] = raw10_byte(grp, k);
            end
        end
    endtask

    task automatic check_packet();
        csi_data_type_e dt;
        logic [15:0]    wc;
        logic [15:0]    crc;
        logic [7:0]     exp_hdr [4];
        int             exp_len;
        int             n;
        int             i;
        if (seq_pos == 0) begin
            if (vc_q.size() == 0) begin
                report_error("packet seen with no frame queued by the stimulus");
            end else begin
                cur_vc = vc_q.pop_front();
            end
        end
        if (seq_pos == 0) begin
            dt = DT_FRAME_START;
        end else if (seq_pos <= LINES) begin
            dt = DT_RAW10;
        end else begin
            dt = DT_FRAME_END;
        end
        wc         = (dt == DT_RAW10) ? 16'(WC) : 16'd0;
        exp_len    = (dt == DT_RAW10) ? WC + 6 : 4;
        exp_hdr[0] = {cur_vc, dt};
        exp_hdr[1] = wc[7:0];
        exp_hdr[2] = wc[15:8];
        exp_hdr[3] = {2'b00, ref_ecc({wc, cur_vc, dt})};
        n          = pkt_bytes.size();
        if (n != exp_len) begin
            report_error($sformatf("packet %0d is %0d bytes long, expected %0d",
                                   pkt_count, n, exp_len));
        end
        for (i = 0; i < 4 && i < n; i++) begin
            compare_byte($sformatf("tx_beat_o.data hdr[%0d] pkt %0d", i, pkt_count),
                         exp_hdr[i], pkt_bytes[i]);
        end
        if (dt == DT_RAW10) begin
            build_payload();
            crc = 16'hFFFF;
            for (i = 0; i < WC; i++) begin
                crc = ref_crc_byte(crc, exp_pay[i]);
                if (4 + i < n) begin
                    compare_byte($sformatf("tx_beat_o.data payload[%0d] pkt %0d", i, pkt_count),
                                 exp_pay[i], pkt_bytes[4+i]);
                end
            end
            // footer goes out low byte first
            if (WC + 4 < n) begin
                compare_byte("tx_beat_o.data crc_lo", crc[7:0], pkt_bytes[WC+4]);
            end
            if (WC + 5 < n) begin
                compare_byte("tx_beat_o.data crc_hi", crc[15:8], pkt_bytes[WC+5]);
            end
        end
        pkt_count++;
        seq_pos = (seq_pos == LINES + 1) ? 0 : seq_pos + 1;
    endtask

    // mid-cycle sampling, outputs settled since the rising edge
    always @(negedge byte_clk) begin
        if (!reset_n_byte) begin
            hs_prev = 1'b0;
            last_en = 1'b0;
            pkt_bytes.delete();
        end else begin
            if (tx_beat_i.en && !hs_req_i) begin
                report_error("tx_beat_o.en high while hs_req_o is low");
            end
            if (tx_beat_i.en && hs_req_i) begin
                pkt_bytes.push_back(tx_beat_i.data);
            end
            // HS falling closes the packet
            if (hs_prev && !hs_req_i) begin
                if (!last_en) begin
                    report_error("hs_req_o stayed high after the last byte of a packet");
                end
                check_packet();
                pkt_bytes.delete();
            end
            hs_prev = hs_req_i;
            last_en = tx_beat_i.en;
        end
    end

endmodule

`default_nettype wire

//--- tb/csi_tx_frontend_chk.sv
// ###########################################################################
// bound protocol checks for the CSI-2 transmit front end
// FIFO overflow, byte strobe outside HS, quiet outputs after reset
// ###########################################################################
`timescale 1ns/100ps
`default_nettype none

module csi_tx_frontend_chk (
    input  wire                     byte_clk,
    input  wire                     reset_n_byte,
    input  csi_pkg::frame_event_t   events_i,
    input  csi_pkg::byte_beat_t     wr_beat_i,
    input  wire                     fifo_full_i,
    input  csi_pkg::byte_beat_t     tx_beat_i,
    input  wire                     hs_req_i
);

    // assertion failures so far
    int fail_count = 0;

    // packer cannot stall so a full FIFO would lose a byte
    no_write_when_full: assert property (
        @(posedge byte_clk) disable iff (!reset_n_byte)
        !(wr_beat_i.en && fifo_full_i)
    ) else begin
        $error("payload FIFO written while full");
        fail_count++;
    end

    // every byte sits inside an HS burst
    no_beat_outside_hs: assert property (
        @(posedge byte_clk) disable iff (!reset_n_byte)
        !(tx_beat_i.en && !hs_req_i)
    ) else begin
        $error("tx_beat_o.en high while hs_req_o low");
        fail_count++;
    end

    // first edge after release still sees reset values
    quiet_after_reset: assert property (
        @(posedge byte_clk)
        $rose(reset_n_byte) |-> ((events_i == '0) && !wr_beat_i.en
                                 && !tx_beat_i.en && !hs_req_i)
    ) else begin
        $error("outputs not low in the first cycle after reset");
        fail_count++;
    end

endmodule

bind csi_tx_frontend csi_tx_frontend_chk csi_tx_frontend_chk_inst (
    .byte_clk     (byte_clk),
    .reset_n_byte (reset_n_byte),
    .events_i     (events),
    .wr_beat_i    (wr_beat),
    .fifo_full_i  (fifo_full),
    .tx_beat_i    (tx_beat_o),
    .hs_req_i     (hs_req_o)
);

`default_nettype wire

//--- tb/tb_csi_tx_frontend.sv
// ###########################################################################
// testbench for the CSI-2 transmit front end
// clock, reset, random RAW10 frames, timeout and closing summary
// ###########################################################################
`timescale 1ns/100ps
`include "csi_config.svh"
`default_nettype none

module tb_csi_tx_frontend;
    import csi_pkg::*;

    localparam int CLK_PERIOD  = 40;
    localparam int FRAMES      = 3;
    localparam int LINES       = 4;
    localparam int LINE_BLANK  = `CSI_LINE_WC + 8;
    localparam int FV_LEAD     = 8;
    localparam int FRAME_BLANK = 16;
    localparam int EXP_PKTS    = FRAMES * (LINES + 2);
    // twice the pixel and blanking time of all frames
    localparam int TIMEOUT_CYCLES = FRAMES * (LINES * (`CSI_LINE_PIXELS * 5 / 4 + LINE_BLANK)
                                    + FV_LEAD + FRAME_BLANK) * 2;

    logic       byte_clk;
    logic       reset_n_byte;
    logic [9:0] pixel_i;
    logic       pixel_valid_i;
    logic       fv_i;
    logic       lv_i;
    logic [1:0] vc_i;
    byte_beat_t tx_beat;
    logic       hs_req;
    integer     seed;
    int         cycle_cnt;
    int         tb_errors = 0;
    int         f;

    csi_tx_frontend csi_tx_frontend_inst (
        .byte_clk      (byte_clk),
        .reset_n_byte  (reset_n_byte),
        .pixel_i       (pixel_i),
        .pixel_valid_i (pixel_valid_i),
        .fv_i          (fv_i),
        .lv_i          (lv_i),
        .vc_i          (vc_i),
        .tx_beat_o     (tx_beat),
        .hs_req_o      (hs_req)
    );

    csi_stream_monitor #(.LINES(LINES)) csi_stream_monitor_inst (
        .byte_clk     (byte_clk),
        .reset_n_byte (reset_n_byte),
        .tx_beat_i    (tx_beat),
        .hs_req_i     (hs_req)
    );

    initial begin
        byte_clk = 1'b0;
        forever #(CLK_PERIOD / 2) byte_clk = ~byte_clk;
    end

    // inputs change 2 ns after the rising edge
    task automatic drive_cycle(input logic fv, input logic lv, input logic valid,
                               input logic [9:0] pix);
        @(posedge byte_clk);
        #2;
        fv_i          = fv;
        lv_i          = lv;
        pixel_valid_i = valid;
        pixel_i       = pix;
    endtask

    task automatic send_line();
        logic [9:0]  pix [`CSI_LINE_PIXELS];
        logic [31:0] rnd;
        int          i;
        for (i = 0; i < `CSI_LINE_PIXELS; i++) begin
            rnd    = $random(seed);
            pix[i] = rnd[9:0];
            csi_stream_monitor_inst.pix_q.push_back(rnd[9:0]);
        end
        drive_cycle(1'b1, 1'b1, 1'b0, 10'd0);
        for (i = 0; i < `CSI_LINE_PIXELS; i++) begin
            rnd = $random(seed);
            // occasional extra stall
            if (rnd[2:0] == 3'd0) begin
                drive_cycle(1'b1, 1'b1, 1'b0, 10'd0);
            end
            drive_cycle(1'b1, 1'b1, 1'b1, pix[i]);
            // free slot after each group for its LSB byte
            if (i % 4 == 3) begin
                drive_cycle(1'b1, 1'b1, 1'b0, 10'd0);
            end
        end
        repeat (LINE_BLANK) drive_cycle(1'b1, 1'b0, 1'b0, 10'd0);
    endtask

    task automatic send_frame(input int frame);
        int l;
        // channel switches while fv is low and well after the previous FE
        csi_stream_monitor_inst.vc_q.push_back(2'(frame + 1));
        drive_cycle(1'b0, 1'b0, 1'b0, 10'd0);
        vc_i = 2'(frame + 1);
        repeat (FV_LEAD) drive_cycle(1'b1, 1'b0, 1'b0, 10'd0);
        for (l = 0; l < LINES; l++) begin
            send_line();
        end
        repeat (FRAME_BLANK) drive_cycle(1'b0, 1'b0, 1'b0, 10'd0);
    endtask

    // monitor, testbench and assertion failures together
    function automatic int total_errors();
        return csi_stream_monitor_inst.err_count + tb_errors
               + csi_tx_frontend_inst.csi_tx_frontend_chk_inst.fail_count;
    endfunction

    task automatic print_summary();
        $display("SUMMARY: checks=%0d errors=%0d assertion_failures=%0d packets=%0d of %0d",
                 csi_stream_monitor_inst.check_count,
                 total_errors(),
                 csi_tx_frontend_inst.csi_tx_frontend_chk_inst.fail_count,
                 csi_stream_monitor_inst.pkt_count, EXP_PKTS);
    endtask

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge byte_clk);
            cycle_cnt++;
        end
        $display("ERROR: timeout after %0d cycles, %0d of %0d packets received",
                 cycle_cnt, csi_stream_monitor_inst.pkt_count, EXP_PKTS);
        tb_errors++;
        print_summary();
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        seed          = 32'ha429;
        reset_n_byte  = 1'b0;
        pixel_i       = 10'd0;
        pixel_valid_i = 1'b0;
        fv_i          = 1'b0;
        lv_i          = 1'b0;
        vc_i          = 2'd0;
        repeat (3) @(posedge byte_clk);
        #2;
        reset_n_byte = 1'b1;
        for (f = 0; f < FRAMES; f++) begin
            send_frame(f);
        end
        while (csi_stream_monitor_inst.pkt_count < EXP_PKTS) begin
            @(posedge byte_clk);
        end
        // room for any stray packet after the last FE
        repeat (2 * `CSI_LINE_WC) @(posedge byte_clk);
        if (csi_stream_monitor_inst.pkt_count != EXP_PKTS) begin
            $display("ERROR: %0d packets received, %0d expected",
                     csi_stream_monitor_inst.pkt_count, EXP_PKTS);
            tb_errors++;
        end
        if (csi_stream_monitor_inst.pix_q.size() != 0) begin
            $display("ERROR: %0d driven pixels never showed up in a long packet",
                     csi_stream_monitor_inst.pix_q.size());
            tb_errors++;
        end
        print_summary();
        if (total_errors() == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire
